// ==== Makefile ====
SIM_BIN = frame_sync_sim

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f frame_sync.f --top-module frame_sync_tb -o $(SIM_BIN)
	@out="$$(./obj_dir/$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== dv/frame_sync_tb.sv ====
`timescale 1ns/10ps

module frame_sync_tb
    import frame_sync_pkg::*;
();

    localparam int ADDR_W     = 11;
    localparam int CLK_PERIOD = 20;

    // kinds of table steps
    localparam int STEP_WRITE = 0;
    localparam int STEP_READ  = 1;
    localparam int STEP_GAP   = 2;
    localparam int STEP_IDLE  = 3;

    // arg is a word offset, a strobe gap or an idle length
    typedef struct {
        int          kind;
        int          arg;
        logic [31:0] data;
        logic [31:0] expected;
    } step_t;

    logic              clk_i = 1'b0;
    logic              reset_ni;
    logic              ssb_strobe_i;
    logic [2:0]        ibar_ssb_i;
    logic [ADDR_W-1:0] s_axi_awaddr_i;
    logic              s_axi_awvalid_i;
    logic              s_axi_awready_o;
    logic [31:0]       s_axi_wdata_i;
    logic [3:0]        s_axi_wstrb_i;
    logic              s_axi_wvalid_i;
    logic              s_axi_wready_o;
    logic [1:0]        s_axi_bresp_o;
    logic              s_axi_bvalid_o;
    logic              s_axi_bready_i;
    logic [ADDR_W-1:0] s_axi_araddr_i;
    logic              s_axi_arvalid_i;
    logic              s_axi_arready_o;
    logic [31:0]       s_axi_rdata_o;
    logic [1:0]        s_axi_rresp_o;
    logic              s_axi_rvalid_o;
    logic              s_axi_rready_i;

    step_t       steps[$];
    int          cycle       = 0;
    int          last_strobe = 0;
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] rng_state   = 32'd85;
    logic        table_ready = 1'b0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    frame_sync_top #(
        .ID            (32'd5),
        .ADDRESS_WIDTH (ADDR_W),
        .NOMINAL_PERIOD(40),
        .TOLERANCE     (2),
        .MAX_MISSED    (3)
    ) dut_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .ssb_strobe_i   (ssb_strobe_i),
        .ibar_ssb_i     (ibar_ssb_i),
        .s_axi_awaddr_i (s_axi_awaddr_i),
        .s_axi_awvalid_i(s_axi_awvalid_i),
        .s_axi_awready_o(s_axi_awready_o),
        .s_axi_wdata_i  (s_axi_wdata_i),
        .s_axi_wstrb_i  (s_axi_wstrb_i),
        .s_axi_wvalid_i (s_axi_wvalid_i),
        .s_axi_wready_o (s_axi_wready_o),
        .s_axi_bresp_o  (s_axi_bresp_o),
        .s_axi_bvalid_o (s_axi_bvalid_o),
        .s_axi_bready_i (s_axi_bready_i),
        .s_axi_araddr_i (s_axi_araddr_i),
        .s_axi_arvalid_i(s_axi_arvalid_i),
        .s_axi_arready_o(s_axi_arready_o),
        .s_axi_rdata_o  (s_axi_rdata_o),
        .s_axi_rresp_o  (s_axi_rresp_o),
        .s_axi_rvalid_o (s_axi_rvalid_o),
        .s_axi_rready_i (s_axi_rready_i)
    );

    function automatic logic [31:0] xorshift32_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string step_name(input int kind);
        case (kind)
            STEP_WRITE: return "write";
            STEP_READ:  return "read";
            STEP_GAP:   return "ssb gap";
            default:    return "idle";
        endcase
    endfunction

    // every stimulus wait goes through here so the cycle count stays exact
    task automatic next_edge();
        @(posedge clk_i);
        cycle = cycle + 1;
    endtask

    task automatic pick_ready_delay(output int delay);
        rng_state = xorshift32_step(rng_state);
        delay = int'(rng_state[1:0]);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count = check_count + 1;
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0d ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic axi_write(input int offset, input logic [31:0] data, output logic [1:0] resp);
        int   delay;
        int   waited;
        logic accepted;
        logic done;
        pick_ready_delay(delay);
        waited   = 0;
        accepted = 1'b0;
        done     = 1'b0;
        s_axi_awaddr_i  <= ADDR_W'(offset * 4);
        s_axi_awvalid_i <= 1'b1;
        s_axi_wdata_i   <= data;
        s_axi_wstrb_i   <= 4'hF;
        s_axi_wvalid_i  <= 1'b1;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = s_axi_awready_o && s_axi_wready_o;
            next_edge();
        end
        s_axi_awvalid_i <= 1'b0;
        s_axi_wvalid_i  <= 1'b0;
        // bready stays low for the chosen number of valid cycles
        while (!done) begin
            @(negedge clk_i);
            if (s_axi_bvalid_o && s_axi_bready_i) begin
                resp = s_axi_bresp_o;
                done = 1'b1;
            end else if (s_axi_bvalid_o) begin
                waited = waited + 1;
            end
            next_edge();
            if (!done && waited >= delay) begin
                s_axi_bready_i <= 1'b1;
            end
        end
        s_axi_bready_i <= 1'b0;
    endtask

    task automatic axi_read(input int offset, output logic [31:0] data, output logic [1:0] resp);
        int   delay;
        int   waited;
        logic accepted;
        logic done;
        pick_ready_delay(delay);
        waited   = 0;
        accepted = 1'b0;
        done     = 1'b0;
        s_axi_araddr_i  <= ADDR_W'(offset * 4);
        s_axi_arvalid_i <= 1'b1;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = s_axi_arready_o;
            next_edge();
        end
        s_axi_arvalid_i <= 1'b0;
        while (!done) begin
            @(negedge clk_i);
            if (s_axi_rvalid_o && s_axi_rready_i) begin
                data = s_axi_rdata_o;
                resp = s_axi_rresp_o;
                done = 1'b1;
            end else if (s_axi_rvalid_o) begin
                waited = waited + 1;
            end
            next_edge();
            if (!done && waited >= delay) begin
                s_axi_rready_i <= 1'b1;
            end
        end
        s_axi_rready_i <= 1'b0;
    endtask

    // gap counts clocks from the previous strobe, 0 pulses at once
    task automatic ssb_gap(input int gap, input logic [2:0] ibar);
        if (gap > 0) begin
            if (cycle > last_strobe + gap - 1) begin
                error_count = error_count + 1;
                $display("Strobe timing lost: a gap of %0d clocks could not be kept", gap);
            end
            while (cycle < last_strobe + gap - 1) begin
                next_edge();
            end
        end
        ssb_strobe_i <= 1'b1;
        ibar_ssb_i   <= ibar;
        next_edge();
        ssb_strobe_i <= 1'b0;
        last_strobe = cycle;
    endtask

    task automatic add_step(input int kind, input int arg, input logic [31:0] data,
                            input logic [31:0] expected);
        step_t s;
        s.kind     = kind;
        s.arg      = arg;
        s.data     = data;
        s.expected = expected;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // identification and unmapped offsets
        add_step(STEP_READ, REG_VERSION, 32'd0, 32'h0001_0061);
        add_step(STEP_READ, REG_ID, 32'd0, 32'd5);
        add_step(STEP_READ, REG_MAGIC, 32'd0, 32'h4653_7E7E);
        add_step(STEP_READ, REG_PATTERN, 32'd0, 32'h6969_6969);
        add_step(STEP_READ, 'h002, 32'd0, 32'd0);
        add_step(STEP_READ, 'h1FF, 32'd0, 32'd0);
        add_step(STEP_READ, REG_STATE, 32'd0, 32'(FS_SEARCH));
        // acquisition
        add_step(STEP_GAP, 0, 32'd1, 32'd0);
        add_step(STEP_GAP, 40, 32'd2, 32'd0);
        add_step(STEP_READ, REG_STATE, 32'd0, 32'(FS_SYNCED));
        add_step(STEP_READ, REG_CLKS_BTWN, 32'd0, 32'd40);
        add_step(STEP_READ, REG_IBAR, 32'd0, 32'd2);
        add_step(STEP_GAP, 40, 32'd3, 32'd0);
        add_step(STEP_READ, REG_IBAR, 32'd0, 32'd3);
        // deviation inside the tolerance window
        add_step(STEP_GAP, 41, 32'd4, 32'd0);
        add_step(STEP_READ, REG_MISMATCH, 32'd0, 32'd1);
        add_step(STEP_READ, REG_CLKS_BTWN, 32'd0, 32'd41);
        add_step(STEP_GAP, 38, 32'd5, 32'd0);
        add_step(STEP_READ, REG_MISMATCH, 32'd0, 32'h0000_00FE);
        add_step(STEP_READ, REG_CLKS_BTWN, 32'd0, 32'd38);
        // three misses end in a disconnect, back to search
        add_step(STEP_IDLE, 180, 32'd0, 32'd0);
        add_step(STEP_READ, REG_MISSED, 32'd0, 32'd3);
        add_step(STEP_READ, REG_DISCONNECTS, 32'd0, 32'd1);
        add_step(STEP_READ, REG_STATE, 32'd0, 32'(FS_SEARCH));
        // reconnect into find, a write to an unmapped offset changes nothing
        add_step(STEP_WRITE, REG_RECONNECT_MODE, 32'd1, 32'd0);
        add_step(STEP_READ, REG_RECONNECT_MODE, 32'd0, 32'd1);
        add_step(STEP_WRITE, 'h007, 32'd0, 32'd0);
        add_step(STEP_READ, REG_RECONNECT_MODE, 32'd0, 32'd1);
        add_step(STEP_GAP, 0, 32'd6, 32'd0);
        add_step(STEP_GAP, 40, 32'd7, 32'd0);
        add_step(STEP_READ, REG_STATE, 32'd0, 32'(FS_SYNCED));
        add_step(STEP_IDLE, 180, 32'd0, 32'd0);
        add_step(STEP_READ, REG_STATE, 32'd0, 32'(FS_FIND));
        add_step(STEP_READ, REG_DISCONNECTS, 32'd0, 32'd2);
        add_step(STEP_READ, REG_MISSED, 32'd0, 32'd6);
    endtask

    initial begin
        int          errors_before;
        logic [31:0] rd;
        logic [1:0]  resp;
        reset_ni        <= 1'b0;
        ssb_strobe_i    <= 1'b0;
        ibar_ssb_i      <= 3'd0;
        s_axi_awaddr_i  <= '0;
        s_axi_awvalid_i <= 1'b0;
        s_axi_wdata_i   <= '0;
        s_axi_wstrb_i   <= '0;
        s_axi_wvalid_i  <= 1'b0;
        s_axi_bready_i  <= 1'b0;
        s_axi_araddr_i  <= '0;
        s_axi_arvalid_i <= 1'b0;
        s_axi_rready_i  <= 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) begin
            next_edge();
        end
        reset_ni <= 1'b1;
        next_edge();
        foreach (steps[i]) begin
            errors_before = error_count;
            case (steps[i].kind)
                STEP_WRITE: begin
                    axi_write(steps[i].arg, steps[i].data, resp);
                    check_value(32'(resp), 32'd0, "write response");
                end
                STEP_READ: begin
                    axi_read(steps[i].arg, rd, resp);
                    check_value(32'(resp), 32'd0, "read response");
                    check_value(rd, steps[i].expected,
                                $sformatf("read of offset 0x%03h", steps[i].arg));
                end
                STEP_GAP: begin
                    ssb_gap(steps[i].arg, steps[i].data[2:0]);
                end
                default: begin
                    repeat (steps[i].arg) begin
                        next_edge();
                    end
                end
            endcase
            $display("step %0d, %s %0d: %s", i, step_name(steps[i].kind), steps[i].arg,
                     (error_count == errors_before) ? "pass" : "fail");
        end
        $display("%0d steps, %0d checks, %0d errors", steps.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // limit is the sum of all gaps and idles plus a margin per step
    initial begin
        int limit;
        wait (table_ready);
        limit = 20;
        foreach (steps[i]) begin
            limit = limit + 20;
            if (steps[i].kind == STEP_GAP || steps[i].kind == STEP_IDLE) begin
                limit = limit + steps[i].arg;
            end
        end
        #(limit * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish within %0d clocks", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== frame_sync.f ====
source/axi_lite_pkg.sv
source/frame_sync_pkg.sv
source/axi_lite_slave.sv
source/frame_sync_regmap.sv
source/ssb_tracker.sv
source/frame_sync_top.sv
dv/frame_sync_tb.sv

// ==== source/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // data width of the register bus
    localparam int AXI_DATA_WIDTH = 32;

    // byte lanes in one data word
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

    // response codes, only OKAY is ever returned
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // width of the word index handed from the bridge to the register map
    localparam int REG_ADDR_WIDTH = 9;

endpackage

// ==== source/axi_lite_slave.sv ====
`timescale 1ns/10ps

module axi_lite_slave
    import axi_lite_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 11
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    // write address and data channels
    input  logic [ADDRESS_WIDTH-1:0]  s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata_i,
    // byte strobes are accepted but every write is a full word
    input  logic [AXI_STRB_WIDTH-1:0] s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,

    // write response channel
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,

    // read address and data channels
    input  logic [ADDRESS_WIDTH-1:0]  s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i,

    // register map side
    output logic                      wreq_o,
    output logic [REG_ADDR_WIDTH-1:0] waddr_o,
    output logic [AXI_DATA_WIDTH-1:0] wdata_o,
    input  logic                      wack_i,
    output logic                      rreq_o,
    output logic [REG_ADDR_WIDTH-1:0] raddr_o,
    input  logic                      rack_i,
    input  logic [AXI_DATA_WIDTH-1:0] rdata_i
);

    logic aw_ready_q;
    logic ar_ready_q;
    logic bvalid_q;
    logic rvalid_q;
    logic wr_busy;
    logic rd_busy;

    // one write and one read may be outstanding at a time
    assign wr_busy = aw_ready_q | wreq_o | wack_i | s_axi_bvalid_o;
    assign rd_busy = ar_ready_q | rreq_o | rack_i | s_axi_rvalid_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            aw_ready_q <= 1'b0;
            ar_ready_q <= 1'b0;
            wreq_o     <= 1'b0;
            rreq_o     <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
        end else begin
            // write needs address and data together
            aw_ready_q <= s_axi_awvalid_i & s_axi_wvalid_i & ~wr_busy;
            ar_ready_q <= s_axi_arvalid_i & ~rd_busy;
            wreq_o     <= aw_ready_q;
            rreq_o     <= ar_ready_q;
            bvalid_q   <= s_axi_bvalid_o & ~s_axi_bready_i;
            rvalid_q   <= s_axi_rvalid_o & ~s_axi_rready_i;
        end
    end

    // byte offset dropped to form the word index
    always_ff @(posedge clk_i) begin
        if (aw_ready_q) begin
            waddr_o <= REG_ADDR_WIDTH'(s_axi_awaddr_i >> 2);
            wdata_o <= s_axi_wdata_i;
        end
        if (ar_ready_q) begin
            raddr_o <= REG_ADDR_WIDTH'(s_axi_araddr_i >> 2);
        end
    end

    assign s_axi_awready_o = aw_ready_q;
    assign s_axi_wready_o  = aw_ready_q;
    assign s_axi_arready_o = ar_ready_q;

    // acknowledge raises valid, the registered copy holds it until ready
    assign s_axi_bvalid_o = wack_i | bvalid_q;
    assign s_axi_rvalid_o = rack_i | rvalid_q;
    assign s_axi_bresp_o  = AXI_RESP_OKAY;
    assign s_axi_rresp_o  = AXI_RESP_OKAY;

    // register map keeps its read word until the next rreq,
    // which cannot come while rvalid is high
    assign s_axi_rdata_o = rdata_i;

    property p_valid_held(logic valid, logic ready);
        @(posedge clk_i) disable iff (!reset_ni)
        valid && !ready |=> valid;
    endproperty

    a_bvalid_held: assert property (p_valid_held(s_axi_bvalid_o, s_axi_bready_i));
    a_rvalid_held: assert property (p_valid_held(s_axi_rvalid_o, s_axi_rready_i));

    a_wreq_pulse: assert property (
        @(posedge clk_i) disable iff (!reset_ni) wreq_o |=> !wreq_o
    );
    a_rreq_pulse: assert property (
        @(posedge clk_i) disable iff (!reset_ni) rreq_o |=> !rreq_o
    );

endmodule

// ==== source/frame_sync_pkg.sv ====
package frame_sync_pkg;

    // tracker states
    typedef enum logic [1:0] {
        FS_SEARCH = 2'd0,
        FS_FIND   = 2'd1,
        FS_SYNCED = 2'd2
    } fs_state_t;

    // register offsets as word indices
    localparam int unsigned REG_VERSION        = 'h000;
    localparam int unsigned REG_ID             = 'h001;
    localparam int unsigned REG_MAGIC          = 'h003;
    localparam int unsigned REG_PATTERN        = 'h004;
    localparam int unsigned REG_STATE          = 'h005;
    localparam int unsigned REG_RECONNECT_MODE = 'h006;
    localparam int unsigned REG_MISMATCH       = 'h009;
    localparam int unsigned REG_MISSED         = 'h00A;
    localparam int unsigned REG_IBAR           = 'h00B;
    localparam int unsigned REG_CLKS_BTWN      = 'h00C;
    localparam int unsigned REG_DISCONNECTS    = 'h00D;

    // identification words
    localparam logic [31:0] CORE_VERSION = 32'h0001_0061;
    // ascii "FS~~"
    localparam logic [31:0] CORE_MAGIC   = 32'h4653_7E7E;
    localparam logic [31:0] CORE_PATTERN = 32'h6969_6969;

    // where the tracker resumes after a disconnect
    // codes 2 and 3 behave like RECONNECT_SEARCH
    localparam logic [1:0] RECONNECT_SEARCH = 2'd0;
    localparam logic [1:0] RECONNECT_FIND   = 2'd1;

endpackage

// ==== source/frame_sync_regmap.sv ====
`timescale 1ns/10ps

module frame_sync_regmap
    import axi_lite_pkg::*;
    import frame_sync_pkg::*;
#(
    parameter logic [31:0] ID = 32'd0
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    // requests from the bus bridge
    input  logic                      wreq_i,
    input  logic [REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [AXI_DATA_WIDTH-1:0] wdata_i,
    output logic                      wack_o,
    input  logic                      rreq_i,
    input  logic [REG_ADDR_WIDTH-1:0] raddr_i,
    output logic                      rack_o,
    output logic [AXI_DATA_WIDTH-1:0] rdata_o,

    // tracker status
    input  fs_state_t                 fs_state_i,
    input  logic [1:0]                reconnect_mode_i,
    input  logic signed [7:0]         sample_cnt_mismatch_i,
    input  logic [15:0]               missed_ssbs_i,
    input  logic [2:0]                ibar_ssb_i,
    input  logic [31:0]               clks_btwn_ssbs_i,
    input  logic [31:0]               num_disconnects_i,

    // reconnect mode update towards the tracker
    output logic                      reconnect_mode_write_o,
    output logic [1:0]                reconnect_mode_o
);

    // acknowledge one cycle after each request
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wack_o <= 1'b0;
            rack_o <= 1'b0;
        end else begin
            wack_o <= wreq_i;
            rack_o <= rreq_i;
        end
    end

    // read word is sampled at the request and held until the next one
    always_ff @(posedge clk_i) begin
        if (rreq_i) begin
            case (32'(raddr_i))
                REG_VERSION:        rdata_o <= AXI_DATA_WIDTH'(CORE_VERSION);
                REG_ID:             rdata_o <= AXI_DATA_WIDTH'(ID);
                REG_MAGIC:          rdata_o <= AXI_DATA_WIDTH'(CORE_MAGIC);
                REG_PATTERN:        rdata_o <= AXI_DATA_WIDTH'(CORE_PATTERN);
                REG_STATE:          rdata_o <= AXI_DATA_WIDTH'(fs_state_i);
                REG_RECONNECT_MODE: rdata_o <= AXI_DATA_WIDTH'(reconnect_mode_i);
                // mismatch shows up zero-extended, the host sign-extends
                REG_MISMATCH:       rdata_o <= AXI_DATA_WIDTH'($unsigned(sample_cnt_mismatch_i));
                REG_MISSED:         rdata_o <= AXI_DATA_WIDTH'(missed_ssbs_i);
                REG_IBAR:           rdata_o <= AXI_DATA_WIDTH'(ibar_ssb_i);
                REG_CLKS_BTWN:      rdata_o <= AXI_DATA_WIDTH'(clks_btwn_ssbs_i);
                REG_DISCONNECTS:    rdata_o <= AXI_DATA_WIDTH'(num_disconnects_i);
                default:            rdata_o <= '0;
            endcase
        end
    end

    // only the reconnect mode is writable, other offsets are acked and dropped
    assign reconnect_mode_write_o = wreq_i && (32'(waddr_i) == REG_RECONNECT_MODE);
    assign reconnect_mode_o       = wdata_i[1:0];

endmodule

// ==== source/frame_sync_top.sv ====
`timescale 1ns/10ps

module frame_sync_top
    import axi_lite_pkg::*;
    import frame_sync_pkg::*;
#(
    parameter logic [31:0] ID             = 32'd0,
    parameter int          ADDRESS_WIDTH  = 11,
    parameter int unsigned NOMINAL_PERIOD = 40,
    parameter int unsigned TOLERANCE      = 2,
    parameter int unsigned MAX_MISSED     = 3
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,

    // SSB detections
    input  logic                      ssb_strobe_i,
    input  logic [2:0]                ibar_ssb_i,

    // host register access
    input  logic [ADDRESS_WIDTH-1:0]  s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [AXI_DATA_WIDTH-1:0] s_axi_wdata_i,
    input  logic [AXI_STRB_WIDTH-1:0] s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,
    input  logic [ADDRESS_WIDTH-1:0]  s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output logic [AXI_DATA_WIDTH-1:0] s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i
);

    logic                      wreq;
    logic [REG_ADDR_WIDTH-1:0] waddr;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      wack;
    logic                      rreq;
    logic [REG_ADDR_WIDTH-1:0] raddr;
    logic                      rack;
    logic [AXI_DATA_WIDTH-1:0] rdata;

    logic                      reconnect_mode_write;
    logic [1:0]                reconnect_mode_wdata;
    fs_state_t                 fs_state;
    logic [1:0]                reconnect_mode;
    logic signed [7:0]         sample_cnt_mismatch;
    logic [15:0]               missed_ssbs;
    logic [2:0]                ibar_ssb;
    logic [31:0]               clks_btwn_ssbs;
    logic [31:0]               num_disconnects;

    axi_lite_slave #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) axi_lite_slave_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .s_axi_awaddr_i (s_axi_awaddr_i),
        .s_axi_awvalid_i(s_axi_awvalid_i),
        .s_axi_awready_o(s_axi_awready_o),
        .s_axi_wdata_i  (s_axi_wdata_i),
        .s_axi_wstrb_i  (s_axi_wstrb_i),
        .s_axi_wvalid_i (s_axi_wvalid_i),
        .s_axi_wready_o (s_axi_wready_o),
        .s_axi_bresp_o  (s_axi_bresp_o),
        .s_axi_bvalid_o (s_axi_bvalid_o),
        .s_axi_bready_i (s_axi_bready_i),
        .s_axi_araddr_i (s_axi_araddr_i),
        .s_axi_arvalid_i(s_axi_arvalid_i),
        .s_axi_arready_o(s_axi_arready_o),
        .s_axi_rdata_o  (s_axi_rdata_o),
        .s_axi_rresp_o  (s_axi_rresp_o),
        .s_axi_rvalid_o (s_axi_rvalid_o),
        .s_axi_rready_i (s_axi_rready_i),
        .wreq_o         (wreq),
        .waddr_o        (waddr),
        .wdata_o        (wdata),
        .wack_i         (wack),
        .rreq_o         (rreq),
        .raddr_o        (raddr),
        .rack_i         (rack),
        .rdata_i        (rdata)
    );

    frame_sync_regmap #(
        .ID(ID)
    ) frame_sync_regmap_i (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .wreq_i                (wreq),
        .waddr_i               (waddr),
        .wdata_i               (wdata),
        .wack_o                (wack),
        .rreq_i                (rreq),
        .raddr_i               (raddr),
        .rack_o                (rack),
        .rdata_o               (rdata),
        .fs_state_i            (fs_state),
        .reconnect_mode_i      (reconnect_mode),
        .sample_cnt_mismatch_i (sample_cnt_mismatch),
        .missed_ssbs_i         (missed_ssbs),
        .ibar_ssb_i            (ibar_ssb),
        .clks_btwn_ssbs_i      (clks_btwn_ssbs),
        .num_disconnects_i     (num_disconnects),
        .reconnect_mode_write_o(reconnect_mode_write),
        .reconnect_mode_o      (reconnect_mode_wdata)
    );

    ssb_tracker #(
        .NOMINAL_PERIOD(NOMINAL_PERIOD),
        .TOLERANCE     (TOLERANCE),
        .MAX_MISSED    (MAX_MISSED)
    ) ssb_tracker_i (
        .clk_i                 (clk_i),
        .reset_ni              (reset_ni),
        .ssb_strobe_i          (ssb_strobe_i),
        .ibar_ssb_i            (ibar_ssb_i),
        .reconnect_mode_write_i(reconnect_mode_write),
        .reconnect_mode_i      (reconnect_mode_wdata),
        .fs_state_o            (fs_state),
        .reconnect_mode_o      (reconnect_mode),
        .sample_cnt_mismatch_o (sample_cnt_mismatch),
        .missed_ssbs_o         (missed_ssbs),
        .ibar_ssb_o            (ibar_ssb),
        .clks_btwn_ssbs_o      (clks_btwn_ssbs),
        .num_disconnects_o     (num_disconnects)
    );

endmodule

// ==== source/ssb_tracker.sv ====
`timescale 1ns/10ps

module ssb_tracker
    import frame_sync_pkg::*;
#(
    parameter int unsigned NOMINAL_PERIOD = 40,
    parameter int unsigned TOLERANCE      = 2,
    parameter int unsigned MAX_MISSED     = 3
) (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic              ssb_strobe_i,
    input  logic [2:0]        ibar_ssb_i,
    input  logic              reconnect_mode_write_i,
    input  logic [1:0]        reconnect_mode_i,
    output fs_state_t         fs_state_o,
    output logic [1:0]        reconnect_mode_o,
    output logic signed [7:0] sample_cnt_mismatch_o,
    output logic [15:0]       missed_ssbs_o,
    output logic [2:0]        ibar_ssb_o,
    output logic [31:0]       clks_btwn_ssbs_o,
    output logic [31:0]       num_disconnects_o
);

    localparam logic [31:0] NOMINAL    = 32'(NOMINAL_PERIOD);
    localparam logic [31:0] LOW_BOUND  = 32'(NOMINAL_PERIOD - TOLERANCE);
    localparam logic [31:0] HIGH_BOUND = 32'(NOMINAL_PERIOD + TOLERANCE);
    localparam int          RUN_W      = $clog2(MAX_MISSED + 1);
    localparam logic [RUN_W-1:0] LAST_RUN = RUN_W'(MAX_MISSED - 1);

    logic [31:0]      clk_cnt_q;
    logic [31:0]      cnt_offset;
    logic [RUN_W-1:0] miss_run_q;
    logic             in_window;
    logic             miss;

    // distance of the current count from the nominal period
    assign cnt_offset = clk_cnt_q - NOMINAL;
    assign in_window  = (clk_cnt_q >= LOW_BOUND) && (clk_cnt_q <= HIGH_BOUND);
    // expected SSB did not show up within the tolerance window
    assign miss = (fs_state_o == FS_SYNCED) && !ssb_strobe_i && (clk_cnt_q > HIGH_BOUND);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            clk_cnt_q         <= '0;
            fs_state_o        <= FS_SEARCH;
            miss_run_q        <= '0;
            missed_ssbs_o     <= '0;
            num_disconnects_o <= '0;
        end else if (ssb_strobe_i) begin
            clk_cnt_q <= 32'd1;
            case (fs_state_o)
                FS_SEARCH: begin
                    fs_state_o <= FS_FIND;
                end
                FS_FIND: begin
                    if (in_window) begin
                        fs_state_o <= FS_SYNCED;
                        miss_run_q <= '0;
                    end
                end
                FS_SYNCED: begin
                    if (in_window) begin
                        miss_run_q <= '0;
                    end
                end
                default: begin
                    fs_state_o <= FS_SEARCH;
                end
            endcase
        end else if (miss) begin
            // step back one period so the next miss lands a period later
            clk_cnt_q <= cnt_offset;
            if (missed_ssbs_o != '1) begin
                missed_ssbs_o <= missed_ssbs_o + 16'd1;
            end
            if (miss_run_q == LAST_RUN) begin
                miss_run_q        <= '0;
                num_disconnects_o <= num_disconnects_o + 32'd1;
                fs_state_o        <= (reconnect_mode_o == RECONNECT_FIND) ? FS_FIND : FS_SEARCH;
            end else begin
                miss_run_q <= miss_run_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 32'd1;
        end
    end

    // measurements captured with each strobe
    always_ff @(posedge clk_i) begin
        if (ssb_strobe_i) begin
            clks_btwn_ssbs_o <= clk_cnt_q;
            ibar_ssb_o       <= ibar_ssb_i;
            if (in_window && fs_state_o != FS_SEARCH) begin
                sample_cnt_mismatch_o <= $signed(cnt_offset[7:0]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            reconnect_mode_o <= RECONNECT_SEARCH;
        end else if (reconnect_mode_write_i) begin
            reconnect_mode_o <= reconnect_mode_i;
        end
    end

    a_state_legal: assert property (
        @(posedge clk_i) disable iff (!reset_ni) 2'(fs_state_o) != 2'd3
    );

endmodule
